/* common/rob_pkg.sv */
////////////////////
// rob_pkg
// shared constants, tag and cause types and the two entry payloads
// of the reorder buffer
////////////////////
package rob_pkg;

    // default number of entries, must be a power of two
    parameter int ROB_DEPTH = 8;

    // address and data width
    parameter int XLEN = 32;

    // tag width for the default depth
    localparam int TAG_W = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] tag_t;    // entry index handed out at dispatch
    typedef logic [4:0]       cause_t;  // exception cause code

    // written once at dispatch, read when the entry reaches the head
    typedef struct packed {
        logic [XLEN-1:0] pc;    // instruction address
        logic [4:0]      dest;  // destination register number
    } disp_payload_t;

    // written by the completion port
    typedef struct packed {
        cause_t cause;  // only meaningful when the entry has its exception bit
    } comp_payload_t;

endpackage

/* common/rob_if.sv */
////////////////////
// alloc_if
// entry write from the allocation stage into the storage
// and retirement stages, with flush travelling back
////////////////////
interface alloc_if
    import rob_pkg::*;
();

    logic          wr_valid;    // dispatch accepted this cycle
    tag_t          wr_tag;      // tail entry being written
    disp_payload_t wr_payload;  // pc and dest of the new entry
    logic          flush;       // drops all entries on an exception

    // allocation side
    modport src (
        output wr_valid,
        output wr_tag,
        output wr_payload,
        input  flush
    );

    // storage and retirement side
    modport sink (
        input  wr_valid,
        input  wr_tag,
        input  wr_payload,
        output flush
    );

endinterface

/* hw/rob/rob_alloc.sv */
////////////////////
// rob_alloc
// tail stage of the reorder buffer
// hands out tags in order, tracks occupancy and
// forwards accepted dispatches as entry writes
////////////////////
module rob_alloc
    import rob_pkg::*;
#(
    parameter int depth = ROB_DEPTH
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          disp_valid,
    input  disp_payload_t disp_payload,
    output logic          disp_ready,
    output tag_t          disp_tag,
    input  logic          pop,          // head entry committed
    alloc_if.src          alloc
);

    localparam int IDX_W = $clog2(depth);
    localparam logic [IDX_W:0] FULL = (IDX_W + 1)'(depth);

    logic [IDX_W-1:0] tail;     // next entry to hand out
    logic [IDX_W:0]   count;    // entries in flight
    logic             fire;     // dispatch handshake

    // no room while full, and nothing accepted during a flush
    assign disp_ready = (count != FULL) && !alloc.flush;
    assign fire       = disp_valid && disp_ready;
    assign disp_tag   = tag_t'(tail);

    assign alloc.wr_valid   = fire;
    assign alloc.wr_tag     = tag_t'(tail);
    assign alloc.wr_payload = disp_payload;

    always_ff @(posedge clk) begin
        if (rst || alloc.flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (fire) begin
                tail <= tail + IDX_W'(1);   // wraps with power of two depth
            end
            case ({fire, pop})
                2'b10:   count <= count + (IDX_W + 1)'(1);
                2'b01:   count <= count - (IDX_W + 1)'(1);
                default: count <= count;    // none, or one in and one out
            endcase
        end
    end

endmodule

/* hw/rob/rob_field_ram.sv */
////////////////////
// rob_field_ram
// per-entry payload store, one write port
// and one asynchronous read port
////////////////////
module rob_field_ram
    import rob_pkg::*;
#(
    parameter int  depth     = ROB_DEPTH,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     wr_en,
    input  tag_t     wr_addr,
    input  payload_t wr_data,
    input  tag_t     rd_addr,
    output payload_t rd_data
);

    localparam int IDX_W = $clog2(depth);

    payload_t         mem [depth];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // tags may be wider than this instance needs
    assign wr_idx = wr_addr[IDX_W-1:0];
    assign rd_idx = rd_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];   // combinational read

endmodule

/* hw/rob/rob_retire.sv */
////////////////////
// rob_retire
// head stage of the reorder buffer
// keeps busy, done and exception bits per entry,
// commits the head in order or raises the exception
// and flushes the buffer
////////////////////
module rob_retire
    import rob_pkg::*;
#(
    parameter int depth = ROB_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    alloc_if.sink           alloc,
    input  logic            comp_valid,
    input  tag_t            comp_tag,
    input  logic            comp_exc,
    output tag_t            head,
    input  disp_payload_t   head_disp,
    input  comp_payload_t   head_comp,
    input  logic [XLEN-1:0] tvec,
    output logic            cm_valid,
    input  logic            cm_ready,
    output logic [XLEN-1:0] cm_pc,
    output logic [4:0]      cm_dest,
    output logic            exc_valid,
    output logic [XLEN-1:0] exc_pc,
    output cause_t          exc_cause,
    output logic [XLEN-1:0] redirect_pc,
    output logic            pop
);

    localparam int IDX_W = $clog2(depth);

    logic [IDX_W-1:0] head_q;       // oldest entry
    logic [depth-1:0] busy;         // entry allocated
    logic [depth-1:0] done;         // completion seen
    logic [depth-1:0] exc;          // completed with exception
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] comp_idx;
    logic             head_ready;   // head allocated and completed

    assign wr_idx   = alloc.wr_tag[IDX_W-1:0];
    assign comp_idx = comp_tag[IDX_W-1:0];
    assign head     = tag_t'(head_q);

    // commit or exception is decided straight from the head bits
    assign head_ready = busy[head_q] && done[head_q];
    assign cm_valid   = head_ready && !exc[head_q];
    assign exc_valid  = head_ready && exc[head_q];

    assign cm_pc   = head_disp.pc;
    assign cm_dest = head_disp.dest;

    assign exc_pc      = head_disp.pc;
    assign exc_cause   = head_comp.cause;
    assign redirect_pc = tvec;          // trap vector

    assign pop         = cm_valid && cm_ready;
    assign alloc.flush = exc_valid;     // one cycle, empties every stage

    always_ff @(posedge clk) begin
        if (rst || exc_valid) begin
            head_q <= '0;
            busy   <= '0;
            done   <= '0;
            exc    <= '0;
        end else begin
            // release the head; a full buffer blocks dispatch,
            // so the tail write below never hits this entry
            if (pop) begin
                busy[head_q] <= 1'b0;
                head_q       <= head_q + IDX_W'(1);
            end
            if (alloc.wr_valid) begin
                busy[wr_idx] <= 1'b1;
                done[wr_idx] <= 1'b0;   // stale status from the last lap
            end
            if (comp_valid) begin
                done[comp_idx] <= 1'b1;
                exc[comp_idx]  <= comp_exc;
            end
        end
    end

endmodule

/* hw/rob/rob_top.sv */
////////////////////
// rob_top
// single-issue reorder buffer
// allocation, entry storage and retirement
// in series behind plain ports
////////////////////
module rob_top
    import rob_pkg::*;
#(
    parameter int depth = ROB_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    // dispatch
    input  logic            disp_valid,
    input  disp_payload_t   disp_payload,
    output logic            disp_ready,
    output tag_t            disp_tag,
    // completion, always accepted
    input  logic            comp_valid,
    input  tag_t            comp_tag,
    input  logic            comp_exc,
    input  cause_t          comp_cause,
    // commit
    output logic            cm_valid,
    input  logic            cm_ready,
    output logic [XLEN-1:0] cm_pc,
    output logic [4:0]      cm_dest,
    // exception
    output logic            exc_valid,
    output logic [XLEN-1:0] exc_pc,
    output cause_t          exc_cause,
    output logic [XLEN-1:0] redirect_pc,
    input  logic [XLEN-1:0] tvec
);

    // pointers wrap only for a power of two that fits in a tag
    if ((depth < 2) || ((depth & (depth - 1)) != 0) || ($clog2(depth) > $bits(tag_t)))
    begin : g_depth_check
        $error("rob_top: depth must be a power of two from 2 to %0d", 2 ** $bits(tag_t));
    end

    alloc_if       alloc_bus ();
    logic          pop;         // commit releases one entry
    tag_t          head;        // oldest entry index
    disp_payload_t head_disp;
    comp_payload_t head_comp;
    comp_payload_t comp_wdata;

    assign comp_wdata.cause = comp_cause;

    rob_alloc #(
        .depth (depth)
    ) u_alloc (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_payload (disp_payload),
        .disp_ready   (disp_ready),
        .disp_tag     (disp_tag),
        .pop          (pop),
        .alloc        (alloc_bus.src)
    );

    rob_field_ram #(
        .depth     (depth),
        .payload_t (disp_payload_t)
    ) ram_disp (
        .clk     (clk),
        .wr_en   (alloc_bus.wr_valid),
        .wr_addr (alloc_bus.wr_tag),
        .wr_data (alloc_bus.wr_payload),
        .rd_addr (head),
        .rd_data (head_disp)
    );

    rob_field_ram #(
        .depth     (depth),
        .payload_t (comp_payload_t)
    ) ram_comp (
        .clk     (clk),
        .wr_en   (comp_valid),
        .wr_addr (comp_tag),
        .wr_data (comp_wdata),
        .rd_addr (head),
        .rd_data (head_comp)
    );

    rob_retire #(
        .depth (depth)
    ) u_retire (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc_bus.sink),
        .comp_valid  (comp_valid),
        .comp_tag    (comp_tag),
        .comp_exc    (comp_exc),
        .head        (head),
        .head_disp   (head_disp),
        .head_comp   (head_comp),
        .tvec        (tvec),
        .cm_valid    (cm_valid),
        .cm_ready    (cm_ready),
        .cm_pc       (cm_pc),
        .cm_dest     (cm_dest),
        .exc_valid   (exc_valid),
        .exc_pc      (exc_pc),
        .exc_cause   (exc_cause),
        .redirect_pc (redirect_pc),
        .pop         (pop)
    );

endmodule

/* verification/rob_props.sv */
////////////////////
// rob_props
// protocol assertions on the reorder buffer ports
// commit and exception exclusion, commit hold and flush timing
////////////////////
module rob_props
    import rob_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic            cm_valid,
    input logic            cm_ready,
    input logic [XLEN-1:0] cm_pc,
    input logic            exc_valid,
    input logic            disp_ready
);

    // head either commits or traps, never both
    a_cm_exc_excl: assert property (
        @(posedge clk) disable iff (rst) !(cm_valid && exc_valid)
    ) else $error("commit and exception raised in the same cycle");

    // stalled commit keeps its data
    a_cm_hold: assert property (
        @(posedge clk) disable iff (rst)
        (cm_valid && !cm_ready) |=> (cm_valid && $stable(cm_pc))
    ) else $error("commit changed while cm_ready was low");

    // no dispatch can slip in during the flush
    a_no_disp_on_exc: assert property (
        @(posedge clk) disable iff (rst) exc_valid |-> !disp_ready
    ) else $error("disp_ready high during an exception");

    a_empty_after_exc: assert property (
        @(posedge clk) disable iff (rst) exc_valid |=> !cm_valid
    ) else $error("commit right after an exception");

endmodule

bind rob_top rob_props u_props (
    .clk        (clk),
    .rst        (rst),
    .cm_valid   (cm_valid),
    .cm_ready   (cm_ready),
    .cm_pc      (cm_pc),
    .exc_valid  (exc_valid),
    .disp_ready (disp_ready)
);

/* verification/rob_tb.sv */
////////////////////
// rob_tb
// table-driven testbench for the reorder buffer
// dispatches rows in order, completes them in random order
// and checks commits and the exception against a program-order model
////////////////////
module rob_tb
    import rob_pkg::*;
();

    localparam int              CLK_PERIOD = 40;
    localparam int              N_ROWS     = 24;
    localparam logic [XLEN-1:0] TRAP_VEC   = 32'h0000_0100;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      dest;
        logic            exc;   // completes with an exception
        cause_t          cause;
    } row_t;

    logic            clk;
    logic            rst;
    logic            disp_valid;
    disp_payload_t   disp_payload;
    logic            disp_ready;
    tag_t            disp_tag;
    logic            comp_valid;
    tag_t            comp_tag;
    logic            comp_exc;
    cause_t          comp_cause;
    logic            cm_valid;
    logic            cm_ready;
    logic [XLEN-1:0] cm_pc;
    logic [4:0]      cm_dest;
    logic            exc_valid;
    logic [XLEN-1:0] exc_pc;
    cause_t          exc_cause;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] tvec;

    row_t            rows [N_ROWS];
    bit              row_done [N_ROWS];
    int              tag_row [ROB_DEPTH];   // row held by each tag
    int              exp_q [$];             // rows in flight in program order
    tag_t            pending [$];           // dispatched but not completed
    int              model_tail;
    int              next_row;
    int              last_row;
    bit              after_exc;
    bit              held;                  // commit stalled last cycle
    logic [XLEN-1:0] held_pc;
    int              err_cnt;
    int              commit_cnt;
    int              exc_cnt;
    int              dropped;               // rows discarded by the flush
    integer          seed = 32'h311fd547;

    rob_top #(
        .depth (ROB_DEPTH)
    ) dut (
        .clk (clk), .rst (rst),
        .disp_valid (disp_valid), .disp_payload (disp_payload),
        .disp_ready (disp_ready), .disp_tag (disp_tag),
        .comp_valid (comp_valid), .comp_tag (comp_tag),
        .comp_exc (comp_exc), .comp_cause (comp_cause),
        .cm_valid (cm_valid), .cm_ready (cm_ready),
        .cm_pc (cm_pc), .cm_dest (cm_dest),
        .exc_valid (exc_valid), .exc_pc (exc_pc), .exc_cause (exc_cause),
        .redirect_pc (redirect_pc), .tvec (tvec)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bound far above the few cycles each row needs
    initial begin
        #(N_ROWS * 64 * CLK_PERIOD);
        $display("timeout: the buffer stopped making progress before the table was done");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic load_table();
        rows[0]  = '{32'h0000_1000, 5'd1,  1'b0, 5'd0};    // full buffer rows
        rows[1]  = '{32'h0000_1004, 5'd2,  1'b0, 5'd0};
        rows[2]  = '{32'h0000_1008, 5'd3,  1'b0, 5'd0};
        rows[3]  = '{32'h0000_100c, 5'd4,  1'b0, 5'd0};
        rows[4]  = '{32'h0000_1010, 5'd5,  1'b0, 5'd0};
        rows[5]  = '{32'h0000_1014, 5'd6,  1'b0, 5'd0};
        rows[6]  = '{32'h0000_1018, 5'd7,  1'b0, 5'd0};
        rows[7]  = '{32'h0000_101c, 5'd8,  1'b0, 5'd0};
        rows[8]  = '{32'h0000_2000, 5'd9,  1'b0, 5'd0};    // order and wrap rows
        rows[9]  = '{32'h0000_2040, 5'd10, 1'b0, 5'd0};
        rows[10] = '{32'h0000_2044, 5'd11, 1'b0, 5'd0};
        rows[11] = '{32'h0000_2100, 5'd12, 1'b0, 5'd0};
        rows[12] = '{32'h0000_2104, 5'd13, 1'b0, 5'd7};    // cause without exception
        rows[13] = '{32'h0000_2108, 5'd14, 1'b0, 5'd0};
        rows[14] = '{32'h0000_3000, 5'd15, 1'b0, 5'd0};
        rows[15] = '{32'h0000_3004, 5'd16, 1'b0, 5'd0};
        rows[16] = '{32'h0000_3ffc, 5'd31, 1'b0, 5'd0};
        rows[17] = '{32'h0000_4000, 5'd0,  1'b0, 5'd0};
        rows[18] = '{32'h0000_5000, 5'd17, 1'b0, 5'd0};    // exception rows
        rows[19] = '{32'h0000_5004, 5'd18, 1'b1, 5'd13};
        rows[20] = '{32'h0000_5008, 5'd19, 1'b0, 5'd0};
        rows[21] = '{32'h0000_500c, 5'd20, 1'b0, 5'd0};
        rows[22] = '{32'h0000_0100, 5'd21, 1'b0, 5'd0};    // handler after redirect
        rows[23] = '{32'h0000_0104, 5'd22, 1'b0, 5'd0};
        for (int i = 0; i < N_ROWS; i++) begin
            row_done[i] = 1'b0;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("ERR %s: expected %0h, actual %0h", name, exp_val, act_val);
        err_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("error: %s", msg);
        err_cnt++;
    endtask

    // checks the settled outputs and then drives the next inputs
    task automatic run_cycle(input string name, input bit hold_comp);
        int   front;
        bit   front_ready;
        bit   front_exc;
        bit   exc_now;
        int   idx;
        tag_t ctag;
        @(negedge clk);
        front       = 0;
        front_ready = 1'b0;
        front_exc   = 1'b0;
        if (exp_q.size() > 0) begin
            front       = exp_q[0];
            front_ready = row_done[front];
            front_exc   = rows[front].exc;
        end
        exc_now = front_ready && front_exc;

        if (cm_valid !== (front_ready && !front_exc)) begin
            report_mismatch({name, " cm_valid"}, 32'(front_ready && !front_exc), 32'(cm_valid));
        end
        if (exc_valid !== exc_now) begin
            report_mismatch({name, " exc_valid"}, 32'(exc_now), 32'(exc_valid));
        end
        if (disp_ready !== (!exc_now && exp_q.size() != ROB_DEPTH)) begin
            report_mismatch({name, " disp_ready"},
                            32'(!exc_now && exp_q.size() != ROB_DEPTH), 32'(disp_ready));
        end
        if (disp_tag !== tag_t'(model_tail)) begin
            report_mismatch({name, " disp_tag"}, 32'(model_tail), 32'(disp_tag));
        end
        if (after_exc && (cm_valid !== 1'b0 || disp_tag !== '0)) begin
            report_failure({name, ": buffer not empty in the cycle after the exception"});
        end
        if (held && cm_valid !== 1'b1) begin
            report_failure({name, ": commit dropped while cm_ready was low"});
        end
        if (held && cm_pc !== held_pc) begin
            report_mismatch({name, " held cm_pc"}, held_pc, cm_pc);
        end
        after_exc = 1'b0;

        if (exc_now) begin
            if (exc_pc !== rows[front].pc) begin
                report_mismatch({name, " exc_pc"}, rows[front].pc, exc_pc);
            end
            if (exc_cause !== rows[front].cause) begin
                report_mismatch({name, " exc_cause"}, 32'(rows[front].cause), 32'(exc_cause));
            end
            if (redirect_pc !== TRAP_VEC) begin
                report_mismatch({name, " redirect_pc"}, TRAP_VEC, redirect_pc);
            end
            exc_cnt++;
            dropped += exp_q.size();    // exception row and everything younger
            exp_q.delete();
            pending.delete();
            model_tail = 0;
            after_exc  = 1'b1;
        end

        cm_ready = (($random(seed) & 3) != 0);
        held     = 1'b0;
        if (!exc_now && front_ready && cm_valid === 1'b1) begin
            if (cm_pc !== rows[front].pc) begin
                report_mismatch({name, " cm_pc"}, rows[front].pc, cm_pc);
            end
            if (cm_dest !== rows[front].dest) begin
                report_mismatch({name, " cm_dest"}, 32'(rows[front].dest), 32'(cm_dest));
            end
            if (cm_ready) begin
                exp_q.delete(0);
                commit_cnt++;
            end else begin
                held    = 1'b1;
                held_pc = rows[front].pc;
            end
        end

        // completion is picked before the dispatch so a new tag waits a cycle
        comp_valid = 1'b0;
        if (!exc_now && !hold_comp && pending.size() > 0 && ($random(seed) & 1) != 0) begin
            idx  = int'(($random(seed) & 32'h7fff_ffff) % pending.size());
            ctag = pending[idx];
            pending.delete(idx);
            comp_valid = 1'b1;
            comp_tag   = ctag;
            comp_exc   = rows[tag_row[ctag]].exc;
            comp_cause = rows[tag_row[ctag]].cause;
            row_done[tag_row[ctag]] = 1'b1;
        end

        disp_valid = 1'b0;
        if (disp_ready === 1'b1 && next_row <= last_row) begin
            disp_valid          = 1'b1;
            disp_payload.pc     = rows[next_row].pc;
            disp_payload.dest   = rows[next_row].dest;
            tag_row[model_tail] = next_row;
            pending.push_back(tag_t'(model_tail));
            exp_q.push_back(next_row);
            model_tail = (model_tail + 1) % ROB_DEPTH;
            next_row++;
        end
    endtask

    // runs rows first..last until the buffer has drained
    task automatic run_phase(input string name, input int first, input int last,
                             input bit fill_first);
        bit hold;
        hold     = fill_first;
        next_row = first;
        last_row = last;
        while (next_row <= last_row || exp_q.size() > 0) begin
            if (exp_q.size() == ROB_DEPTH) begin
                hold = 1'b0;    // completions may start once the buffer is full
            end
            run_cycle(name, hold);
        end
    endtask

    initial begin
        rst          = 1'b1;
        disp_valid   = 1'b0;
        disp_payload = '0;
        comp_valid   = 1'b0;
        comp_tag     = '0;
        comp_exc     = 1'b0;
        comp_cause   = '0;
        cm_ready     = 1'b0;
        tvec         = TRAP_VEC;
        model_tail   = 0;
        after_exc    = 1'b0;
        held         = 1'b0;
        held_pc      = '0;
        err_cnt      = 0;
        commit_cnt   = 0;
        exc_cnt      = 0;
        dropped      = 0;
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_phase("full_buffer", 0, 7, 1'b1);
        run_phase("order_wrap", 8, 17, 1'b0);
        run_phase("exception", 18, 21, 1'b0);
        run_phase("after_exception", 22, 23, 1'b0);

        if (exc_cnt != 1) begin
            report_mismatch("exception count", 32'd1, 32'(exc_cnt));
        end
        if (commit_cnt != N_ROWS - dropped) begin
            report_mismatch("commit count", 32'(N_ROWS - dropped), 32'(commit_cnt));
        end
        $display("errors: %0d, commits: %0d, exceptions: %0d, dropped rows: %0d",
                 err_cnt, commit_cnt, exc_cnt, dropped);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
common/rob_pkg.sv
common/rob_if.sv
hw/rob/rob_alloc.sv
hw/rob/rob_field_ram.sv
hw/rob/rob_retire.sv
hw/rob/rob_top.sv
verification/rob_props.sv
verification/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert \
    --top-module rob_tb \
    -f sources.f \
    --Mdir "$BUILD_DIR" \
    -o rob_sim

"./$BUILD_DIR/rob_sim" | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
